// File: verilog/doe_pkg.sv
`default_nettype none

package doe_pkg;

  // ------------------------------------------------------------------
  // Widths
  // ------------------------------------------------------------------
  localparam int WORD_W  = 32;
  localparam int ADDR_W  = 8;
  localparam int BLOCK_W = 64;
  localparam int KEY_W   = 128;
  localparam int DEST_W  = 3;
  localparam int SLOT_W  = 2;
  localparam int CMD_W   = 2;

  // Blocks per flow
  localparam int UDS_BLOCKS = 4;
  localparam int FE_BLOCKS  = 2;

  // XTEA constants, one full round per cycle
  localparam int                XTEA_CYCLES = 32;
  localparam logic [WORD_W-1:0] XTEA_DELTA  = 32'h9e37_79b9;

  typedef logic [WORD_W-1:0]             doe_word_t;
  typedef logic [ADDR_W-1:0]             doe_addr_t;
  typedef logic [BLOCK_W-1:0]            doe_block_t;
  typedef logic [KEY_W-1:0]              doe_key_t;
  typedef logic [UDS_BLOCKS*BLOCK_W-1:0] doe_uds_t;
  typedef logic [FE_BLOCKS*BLOCK_W-1:0]  doe_fe_t;
  typedef logic [DEST_W-1:0]             doe_dest_t;
  typedef logic [SLOT_W-1:0]             doe_slot_t;

  typedef enum logic [CMD_W-1:0] {
    CMD_IDLE  = 2'd0,
    CMD_UDS   = 2'd1,
    CMD_FE    = 2'd2,
    CMD_CLEAR = 2'd3
  } doe_cmd_e;

  // Flow controller only
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOAD,
    ST_WAIT_CORE,
    ST_WRITE,
    ST_DONE
  } doe_flow_state_e;

  // ------------------------------------------------------------------
  // Register map, byte offsets
  // ------------------------------------------------------------------
  localparam doe_addr_t REG_IV0      = 8'h00;
  localparam doe_addr_t REG_IV1      = 8'h04;
  localparam doe_addr_t REG_CTRL     = 8'h08;
  localparam doe_addr_t REG_STATUS   = 8'h0c;
  localparam doe_addr_t REG_INTR_STS = 8'h10;
  localparam doe_addr_t REG_INTR_EN  = 8'h14;

  // CTRL fields
  localparam int CTRL_CMD_LSB  = 0;
  localparam int CTRL_DEST_LSB = 2;

  // STATUS bits
  localparam int STS_READY    = 0;
  localparam int STS_VALID    = 1;
  localparam int STS_UDS_DONE = 2;
  localparam int STS_FE_DONE  = 3;
  localparam int STS_CLEARED  = 4;

  // Interrupt bits, shared by INTR_STS and INTR_EN
  localparam int INTR_NOTIF = 0;
  localparam int INTR_ERROR = 1;

endpackage

`default_nettype wire

// File: verilog/doe_core_if.sv
`timescale 1ns/1ps
`default_nettype none

interface doe_core_if;
  import doe_pkg::*;

  // Flow controller side
  logic       start;
  doe_block_t block_in;
  logic       zeroize;

  // Cipher core side
  doe_block_t result;
  logic       valid;
  logic       ready;

  // start only while ready, result held until next start or zeroize
  modport ctrl (
    output start,
    output block_in,
    output zeroize,
    input  result,
    input  valid,
    input  ready
  );

  modport core (
    input  start,
    input  block_in,
    input  zeroize,
    output result,
    output valid,
    output ready
  );

endinterface

`default_nettype wire

// File: verilog/doe_reg_block.sv
`timescale 1ns/1ps
`default_nettype none

module doe_reg_block (
  input  logic                clk,
  input  logic                reset_n,
  // CPU port
  input  logic                cs,
  input  logic                we,
  input  doe_pkg::doe_addr_t  address,
  input  doe_pkg::doe_word_t  write_data,
  output doe_pkg::doe_word_t  read_data,
  // To cipher core
  output doe_pkg::doe_block_t iv,
  output logic                iv_updated,
  input  logic                core_ready,
  // To and from flow controller
  output doe_pkg::doe_cmd_e   cmd,
  output doe_pkg::doe_dest_t  dest,
  input  logic                busy,
  input  logic                flow_done,
  input  logic                cmd_reject,
  input  logic                secrets_cleared,
  input  logic                uds_locked,
  input  logic                fe_locked,
  input  logic                cleared_state,
  // Interrupts
  output logic                error_intr,
  output logic                notif_intr
);
  import doe_pkg::*;

  doe_word_t  iv0_q;
  doe_word_t  iv1_q;
  logic       status_ready;
  logic       status_valid;
  logic [1:0] intr_sts;
  logic [1:0] intr_en;
  logic [1:0] intr_set;
  logic       wr_en;
  logic       rd_en;
  logic       wr_iv0;
  logic       wr_iv1;
  logic       wr_ctrl;
  logic       wr_intr_sts;
  logic       wr_intr_en;
  doe_word_t  rd_mux;

  // ------------------------------------------------------------------
  // Access decode
  // ------------------------------------------------------------------
  assign wr_en       = cs && we;
  assign rd_en       = cs && !we;
  assign wr_iv0      = wr_en && (address == REG_IV0);
  assign wr_iv1      = wr_en && (address == REG_IV1);
  assign wr_ctrl     = wr_en && (address == REG_CTRL);
  assign wr_intr_sts = wr_en && (address == REG_INTR_STS);
  assign wr_intr_en  = wr_en && (address == REG_INTR_EN);

  assign iv = {iv1_q, iv0_q};

  // Ready only when core idle and no flow running
  assign status_ready = core_ready && !busy;

  // Hardware set events, error in bit 1, notif in bit 0
  assign intr_set = {cmd_reject, flow_done};

  // IV, dest and enables
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      iv0_q      <= '0;
      iv1_q      <= '0;
      dest       <= '0;
      intr_en    <= '0;
      iv_updated <= 1'b0;
    end else begin
      // One cycle late so the core sees the new value
      iv_updated <= wr_iv0 || wr_iv1;
      if (wr_iv0) begin
        iv0_q <= write_data;
      end
      if (wr_iv1) begin
        iv1_q <= write_data;
      end
      if (wr_ctrl) begin
        dest <= write_data[CTRL_DEST_LSB +: DEST_W];
      end
      if (wr_intr_en) begin
        intr_en <= write_data[1:0];
      end
    end
  end

  // Command, cleared by hardware when the flow ends or is refused
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      cmd <= CMD_IDLE;
    end else if (wr_ctrl) begin
      cmd <= doe_cmd_e'(write_data[CTRL_CMD_LSB +: CMD_W]);
    end else if (flow_done || cmd_reject || secrets_cleared) begin
      cmd <= CMD_IDLE;
    end
  end

  // Sticky valid and W1C interrupt status
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      status_valid <= 1'b0;
      intr_sts     <= '0;
    end else begin
      if (flow_done || secrets_cleared) begin
        status_valid <= 1'b1;
      end else if (wr_ctrl) begin
        status_valid <= 1'b0;
      end
      // Set wins over clear
      intr_sts <= (wr_intr_sts ? (intr_sts & ~write_data[1:0]) : intr_sts) | intr_set;
    end
  end

  assign notif_intr = intr_sts[INTR_NOTIF] && intr_en[INTR_NOTIF];
  assign error_intr = intr_sts[INTR_ERROR] && intr_en[INTR_ERROR];

  // ------------------------------------------------------------------
  // Read path
  // ------------------------------------------------------------------
  always_comb begin
    rd_mux = '0;
    case (address)
      REG_IV0: rd_mux = iv0_q;
      REG_IV1: rd_mux = iv1_q;
      REG_CTRL: begin
        rd_mux[CTRL_CMD_LSB +: CMD_W]   = cmd;
        rd_mux[CTRL_DEST_LSB +: DEST_W] = dest;
      end
      REG_STATUS: begin
        rd_mux[STS_READY]    = status_ready;
        rd_mux[STS_VALID]    = status_valid;
        rd_mux[STS_UDS_DONE] = uds_locked;
        rd_mux[STS_FE_DONE]  = fe_locked;
        rd_mux[STS_CLEARED]  = cleared_state;
      end
      REG_INTR_STS: rd_mux[1:0] = intr_sts;
      REG_INTR_EN:  rd_mux[1:0] = intr_en;
      default:      rd_mux = '0;
    endcase
  end

  // Registered read data, held between reads
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      read_data <= '0;
    end else if (rd_en) begin
      read_data <= rd_mux;
    end
  end

endmodule

`default_nettype wire

// File: verilog/doe_cbc_core.sv
`timescale 1ns/1ps
`default_nettype none

module doe_cbc_core (
  input  logic                clk,
  input  logic                reset_n,
  input  doe_pkg::doe_block_t iv,
  input  logic                iv_updated,
  input  doe_pkg::doe_key_t   key,
  doe_core_if.core            core_if
);
  import doe_pkg::*;

  // Sum after all rounds of the forward direction
  localparam doe_word_t  SUM_INIT   = doe_word_t'(XTEA_DELTA * XTEA_CYCLES);
  localparam logic [4:0] LAST_ROUND = 5'(XTEA_CYCLES - 1);

  logic       busy;
  logic [4:0] round;
  logic       last_round;
  logic       load;
  logic       valid_q;
  doe_word_t  v0;
  doe_word_t  v1;
  doe_word_t  sum;
  doe_word_t  v0_n;
  doe_word_t  v1_n;
  doe_word_t  sum_n;
  doe_block_t ct_q;
  doe_block_t chain_q;
  doe_block_t result_q;

  // XTEA feistel mix
  function automatic doe_word_t xtea_mix(input doe_word_t v);
    return ((v << 4) ^ (v >> 5)) + v;
  endfunction

  assign load       = core_if.start && !busy;
  assign last_round = busy && (round == LAST_ROUND);

  // ------------------------------------------------------------------
  // One decrypt round per cycle
  // ------------------------------------------------------------------
  always_comb begin
    v1_n  = v1 - (xtea_mix(v0) ^ (sum + key[{sum[12:11], 5'd0} +: 32]));
    sum_n = sum - XTEA_DELTA;
    v0_n  = v0 - (xtea_mix(v1_n) ^ (sum_n + key[{sum_n[1:0], 5'd0} +: 32]));
  end

  // Round state, v0 in low word of the block
  always_ff @(posedge clk) begin
    if (core_if.zeroize) begin
      v0   <= '0;
      v1   <= '0;
      sum  <= '0;
      ct_q <= '0;
    end else if (load) begin
      v0   <= core_if.block_in[31:0];
      v1   <= core_if.block_in[63:32];
      sum  <= SUM_INIT;
      ct_q <= core_if.block_in;
    end else if (busy) begin
      v0  <= v0_n;
      v1  <= v1_n;
      sum <= sum_n;
    end
  end

  // Control, chaining and result
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      busy     <= 1'b0;
      round    <= '0;
      valid_q  <= 1'b0;
      chain_q  <= '0;
      result_q <= '0;
    end else if (core_if.zeroize) begin
      busy     <= 1'b0;
      round    <= '0;
      valid_q  <= 1'b0;
      chain_q  <= '0;
      result_q <= '0;
    end else begin
      valid_q <= 1'b0;
      if (load) begin
        busy  <= 1'b1;
        round <= '0;
      end else if (busy) begin
        round <= round + 5'd1;
      end
      if (last_round) begin
        busy     <= 1'b0;
        valid_q  <= 1'b1;
        // CBC: plaintext = D(ct) ^ previous ct
        result_q <= {v1_n, v0_n} ^ chain_q;
        chain_q  <= ct_q;
      end else if (iv_updated) begin
        chain_q <= iv;
      end
    end
  end

  assign core_if.ready  = !busy;
  assign core_if.valid  = valid_q;
  assign core_if.result = result_q;

endmodule

`default_nettype wire

// File: verilog/doe_flow_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module doe_flow_ctrl (
  input  logic                clk,
  input  logic                reset_n,
  input  doe_pkg::doe_cmd_e   cmd,
  input  doe_pkg::doe_dest_t  dest,
  input  doe_pkg::doe_uds_t   obf_uds_seed,
  input  doe_pkg::doe_fe_t    obf_field_entropy,
  doe_core_if.ctrl            ctrl_if,
  // Key vault write port
  output logic                kv_write_en,
  output doe_pkg::doe_dest_t  kv_write_entry,
  output doe_pkg::doe_slot_t  kv_write_slot,
  output doe_pkg::doe_block_t kv_write_data,
  // Events and status
  output logic                flow_done,
  output logic                cmd_reject,
  output logic                secrets_cleared,
  output logic                clear_obf_secrets,
  output logic                busy,
  output logic                uds_locked,
  output logic                fe_locked,
  output logic                cleared_state
);
  import doe_pkg::*;

  doe_flow_state_e state;
  doe_flow_state_e state_n;
  doe_slot_t       blk_idx;
  doe_slot_t       last_idx;
  doe_dest_t       dest_q;
  logic            flow_uds;
  logic            in_idle;
  logic            want_uds;
  logic            want_fe;
  logic            uds_ok;
  logic            fe_ok;
  logic            accept;

  // ------------------------------------------------------------------
  // Command check, only in IDLE
  // ------------------------------------------------------------------
  assign in_idle  = (state == ST_IDLE);
  assign want_uds = in_idle && (cmd == CMD_UDS);
  assign want_fe  = in_idle && (cmd == CMD_FE);
  assign uds_ok   = !uds_locked && !cleared_state;
  assign fe_ok    = !fe_locked && !cleared_state;
  assign accept   = (want_uds && uds_ok) || (want_fe && fe_ok);

  // One cycle each, cmd is cleared right after
  assign cmd_reject        = (want_uds && !uds_ok) || (want_fe && !fe_ok);
  assign secrets_cleared   = in_idle && (cmd == CMD_CLEAR);
  assign clear_obf_secrets = secrets_cleared;
  assign ctrl_if.zeroize   = secrets_cleared;

  assign last_idx = flow_uds ? doe_slot_t'(UDS_BLOCKS - 1) : doe_slot_t'(FE_BLOCKS - 1);

  always_comb begin
    state_n = state;
    case (state)
      ST_IDLE:      if (accept) state_n = ST_LOAD;
      ST_LOAD:      if (ctrl_if.ready) state_n = ST_WAIT_CORE;
      ST_WAIT_CORE: if (ctrl_if.valid) state_n = ST_WRITE;
      ST_WRITE:     state_n = (blk_idx == last_idx) ? ST_DONE : ST_LOAD;
      ST_DONE:      state_n = ST_IDLE;
      default:      state_n = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state         <= ST_IDLE;
      blk_idx       <= '0;
      flow_uds      <= 1'b0;
      dest_q        <= '0;
      uds_locked    <= 1'b0;
      fe_locked     <= 1'b0;
      cleared_state <= 1'b0;
    end else begin
      state <= state_n;
      // Latch flow type and destination at accept
      if (accept) begin
        blk_idx  <= '0;
        flow_uds <= want_uds;
        dest_q   <= dest;
      end
      if ((state == ST_WRITE) && (blk_idx != last_idx)) begin
        blk_idx <= blk_idx + 2'd1;
      end
      // Locks stay set until reset
      if (flow_done) begin
        uds_locked <= uds_locked || flow_uds;
        fe_locked  <= fe_locked || !flow_uds;
      end
      if (secrets_cleared) begin
        cleared_state <= 1'b1;
      end
    end
  end

  // ------------------------------------------------------------------
  // Core feed, lowest block first
  // ------------------------------------------------------------------
  always_comb begin
    if (flow_uds) begin
      ctrl_if.block_in = obf_uds_seed[blk_idx*BLOCK_W +: BLOCK_W];
    end else begin
      ctrl_if.block_in = obf_field_entropy[blk_idx[0]*BLOCK_W +: BLOCK_W];
    end
  end

  assign ctrl_if.start = (state == ST_LOAD) && ctrl_if.ready;

  // Key vault write, result held by the core during WRITE
  assign kv_write_en    = (state == ST_WRITE);
  assign kv_write_entry = dest_q;
  assign kv_write_slot  = blk_idx;
  assign kv_write_data  = ctrl_if.result;

  assign flow_done = (state == ST_DONE);
  assign busy      = !in_idle;

endmodule

`default_nettype wire

// File: verilog/doe_cbc.sv
`timescale 1ns/1ps
`default_nettype none

module doe_cbc (
  input  logic                clk,
  input  logic                reset_n,
  // CPU register port
  input  logic                cs,
  input  logic                we,
  input  doe_pkg::doe_addr_t  address,
  input  doe_pkg::doe_word_t  write_data,
  output doe_pkg::doe_word_t  read_data,
  // Obfuscated secrets and key
  input  doe_pkg::doe_key_t   obf_key,
  input  doe_pkg::doe_uds_t   obf_uds_seed,
  input  doe_pkg::doe_fe_t    obf_field_entropy,
  // Key vault write port
  output logic                kv_write_en,
  output doe_pkg::doe_dest_t  kv_write_entry,
  output doe_pkg::doe_slot_t  kv_write_slot,
  output doe_pkg::doe_block_t kv_write_data,
  output logic                clear_obf_secrets,
  output logic                error_intr,
  output logic                notif_intr
);
  import doe_pkg::*;

  doe_block_t iv;
  logic       iv_updated;
  doe_cmd_e   cmd;
  doe_dest_t  dest;
  logic       busy;
  logic       flow_done;
  logic       cmd_reject;
  logic       secrets_cleared;
  logic       uds_locked;
  logic       fe_locked;
  logic       cleared_state;

  // Flow controller to cipher core
  doe_core_if core_if ();

  // ------------------------------------------------------------------
  // Registers
  // ------------------------------------------------------------------
  doe_reg_block u_reg_block (
    .clk             (clk),
    .reset_n         (reset_n),
    .cs              (cs),
    .we              (we),
    .address         (address),
    .write_data      (write_data),
    .read_data       (read_data),
    .iv              (iv),
    .iv_updated      (iv_updated),
    .core_ready      (core_if.ready),
    .cmd             (cmd),
    .dest            (dest),
    .busy            (busy),
    .flow_done       (flow_done),
    .cmd_reject      (cmd_reject),
    .secrets_cleared (secrets_cleared),
    .uds_locked      (uds_locked),
    .fe_locked       (fe_locked),
    .cleared_state   (cleared_state),
    .error_intr      (error_intr),
    .notif_intr      (notif_intr)
  );

  // XTEA-CBC decrypt
  doe_cbc_core u_cbc_core (
    .clk        (clk),
    .reset_n    (reset_n),
    .iv         (iv),
    .iv_updated (iv_updated),
    .key        (obf_key),
    .core_if    (core_if.core)
  );

  // Sequencing and key vault writes
  doe_flow_ctrl u_flow_ctrl (
    .clk               (clk),
    .reset_n           (reset_n),
    .cmd               (cmd),
    .dest              (dest),
    .obf_uds_seed      (obf_uds_seed),
    .obf_field_entropy (obf_field_entropy),
    .ctrl_if           (core_if.ctrl),
    .kv_write_en       (kv_write_en),
    .kv_write_entry    (kv_write_entry),
    .kv_write_slot     (kv_write_slot),
    .kv_write_data     (kv_write_data),
    .flow_done         (flow_done),
    .cmd_reject        (cmd_reject),
    .secrets_cleared   (secrets_cleared),
    .clear_obf_secrets (clear_obf_secrets),
    .busy              (busy),
    .uds_locked        (uds_locked),
    .fe_locked         (fe_locked),
    .cleared_state     (cleared_state)
  );

endmodule

`default_nettype wire

// File: testbench/doe_tb_model.svh
`ifndef DOE_TB_MODEL_SVH
`define DOE_TB_MODEL_SVH

// ------------------------------------------------------------------
// XTEA reference, decrypt direction
// ------------------------------------------------------------------

// v0 in the low word, key word 0 in bits 31:0
function automatic doe_block_t xtea_decrypt_block(input doe_block_t ct, input doe_key_t key);
  doe_word_t k [4];
  doe_word_t y;
  doe_word_t z;
  doe_word_t sum;
  int        i;
  for (i = 0; i < 4; i++) begin
    k[i] = key[32*i +: 32];
  end
  y = ct[31:0];
  z = ct[63:32];
  // Delta times 32, modulo 2^32
  sum = 32'hc6ef_3720;
  for (i = 0; i < 32; i++) begin
    z   = z - ((((y << 4) ^ (y >> 5)) + y) ^ (sum + k[sum[12:11]]));
    sum = sum - 32'h9e37_79b9;
    y   = y - ((((z << 4) ^ (z >> 5)) + z) ^ (sum + k[sum[1:0]]));
  end
  return {z, y};
endfunction

// CBC plaintext for block index of a source, lowest block first
function automatic doe_block_t cbc_expected(input doe_key_t key, input doe_block_t iv,
                                            input doe_uds_t src, input int index);
  doe_block_t ct;
  doe_block_t prev;
  ct = src[index*64 +: 64];
  if (index == 0) begin
    prev = iv;
  end else begin
    prev = src[(index-1)*64 +: 64];
  end
  return xtea_decrypt_block(ct, key) ^ prev;
endfunction

// Register words as firmware would read them
function automatic doe_word_t status_word(input logic ready, input logic valid,
                                          input logic uds_done, input logic fe_done,
                                          input logic cleared);
  return {27'd0, cleared, fe_done, uds_done, valid, ready};
endfunction

function automatic doe_word_t ctrl_word(input doe_cmd_e cmd, input doe_dest_t dest);
  return {27'd0, dest, cmd};
endfunction

function automatic doe_word_t intr_word(input logic error, input logic notif);
  return {30'd0, error, notif};
endfunction

`endif

// File: testbench/doe_cbc_tb.sv
`timescale 1ns/1ps
`default_nettype none

module doe_cbc_tb;
  import doe_pkg::*;

  `include "doe_tb_model.svh"

  localparam int HALF_PERIOD     = 10;
  localparam int CLK_PERIOD      = 2 * HALF_PERIOD;
  localparam int RESET_CYCLES    = 4;
  // Cycle budget per test for six tests
  localparam int TEST_BUDGET     = 200;
  localparam int WATCHDOG_CYCLES = 6 * TEST_BUDGET + RESET_CYCLES;
  // Two cycles per STATUS poll
  localparam int POLL_LIMIT      = 100;
  // LOAD, the core run and WRITE of one block
  localparam int BLOCK_CYCLES    = XTEA_CYCLES + 3;
  localparam int SEED            = 23;

  logic       clk;
  logic       reset_n;
  logic       cs;
  logic       we;
  doe_addr_t  address;
  doe_word_t  write_data;
  doe_word_t  read_data;
  doe_key_t   obf_key;
  doe_uds_t   obf_uds_seed;
  doe_fe_t    obf_field_entropy;
  logic       kv_write_en;
  doe_dest_t  kv_write_entry;
  doe_slot_t  kv_write_slot;
  doe_block_t kv_write_data;
  logic       clear_obf_secrets;
  logic       error_intr;
  logic       notif_intr;

  // Expected key vault traffic in arrival order
  doe_block_t exp_data[$];
  doe_slot_t  exp_slot[$];
  doe_dest_t  exp_entry[$];

  int errors       = 0;
  int test_errors  = 0;
  int tests_run    = 0;
  int tests_failed = 0;
  int kv_count     = 0;
  int clear_count  = 0;

  doe_cbc u_dut (
    .clk               (clk),
    .reset_n           (reset_n),
    .cs                (cs),
    .we                (we),
    .address           (address),
    .write_data        (write_data),
    .read_data         (read_data),
    .obf_key           (obf_key),
    .obf_uds_seed      (obf_uds_seed),
    .obf_field_entropy (obf_field_entropy),
    .kv_write_en       (kv_write_en),
    .kv_write_entry    (kv_write_entry),
    .kv_write_slot     (kv_write_slot),
    .kv_write_data     (kv_write_data),
    .clear_obf_secrets (clear_obf_secrets),
    .error_intr        (error_intr),
    .notif_intr        (notif_intr)
  );

  always #HALF_PERIOD clk = ~clk;

  // ------------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------------
  task automatic report_mismatch(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
    $display("CHECK FAILED at %0d ns: %s expected %h got %h", $time, name, expected, actual);
    errors++;
  endtask

  task automatic begin_test();
    test_errors = errors;
  endtask

  task automatic end_test(input int num, input string name);
    tests_run++;
    if (errors != test_errors) begin
      tests_failed++;
      $display("test %0d %s: FAIL", num, name);
    end else begin
      $display("test %0d %s: ok", num, name);
    end
  endtask

  // CPU write with strobes held for one edge
  task automatic reg_write(input doe_addr_t addr, input doe_word_t data);
    @(negedge clk);
    cs         = 1'b1;
    we         = 1'b1;
    address    = addr;
    write_data = data;
    @(negedge clk);
    cs = 1'b0;
    we = 1'b0;
  endtask

  // Registered read returns data one cycle later
  task automatic reg_read(input doe_addr_t addr, output doe_word_t data);
    @(negedge clk);
    cs      = 1'b1;
    we      = 1'b0;
    address = addr;
    @(negedge clk);
    cs   = 1'b0;
    data = read_data;
  endtask

  task automatic wait_status_valid();
    doe_word_t rd;
    int        polls;
    logic      seen;
    seen  = 1'b0;
    polls = 0;
    while (!seen && (polls < POLL_LIMIT)) begin
      reg_read(REG_STATUS, rd);
      seen = rd[STS_VALID];
      polls++;
    end
    if (!seen) begin
      $display("STATUS.valid never rose within %0d polls, at %0d ns", POLL_LIMIT, $time);
      errors++;
    end
  endtask

  // Queue the reference plaintext of every block of a flow
  task automatic expect_flow(input doe_block_t iv, input doe_uds_t src, input int nblocks,
                             input doe_dest_t dest);
    int i;
    for (i = 0; i < nblocks; i++) begin
      exp_data.push_back(cbc_expected(obf_key, iv, src, i));
      exp_slot.push_back(doe_slot_t'(i));
      exp_entry.push_back(dest);
    end
  endtask

  // ------------------------------------------------------------------
  // Key vault checker and clear pulse counter
  // ------------------------------------------------------------------
  always @(negedge clk) begin
    if (reset_n && kv_write_en) begin
      kv_count++;
      if (exp_data.size() == 0) begin
        $display("Unexpected key vault write at %0d ns, entry %0d slot %0d",
                 $time, kv_write_entry, kv_write_slot);
        errors++;
      end else begin
        if (kv_write_slot !== exp_slot[0]) begin
          report_mismatch("kv_write_slot", 64'(exp_slot[0]), 64'(kv_write_slot));
        end
        if (kv_write_entry !== exp_entry[0]) begin
          report_mismatch("kv_write_entry", 64'(exp_entry[0]), 64'(kv_write_entry));
        end
        if (kv_write_data !== exp_data[0]) begin
          report_mismatch("kv_write_data", exp_data[0], kv_write_data);
        end
        exp_data.delete(0);
        exp_slot.delete(0);
        exp_entry.delete(0);
      end
    end
  end

  always @(negedge clk) begin
    if (reset_n && clear_obf_secrets) begin
      clear_count++;
    end
  end

  // Stops a hung run
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
    $display("tests failed");
    $finish;
  end

  // ------------------------------------------------------------------
  // Tests
  // ------------------------------------------------------------------
  initial begin
    doe_word_t  rd;
    doe_block_t iv_a;
    doe_block_t iv_b;
    doe_dest_t  dest_a;
    doe_dest_t  dest_b;
    int         kv_before;
    int         clr_before;
    int         i;

    clk        = 1'b0;
    reset_n    = 1'b0;
    cs         = 1'b0;
    we         = 1'b0;
    address    = '0;
    write_data = '0;
    void'($urandom(SEED));
    for (i = 0; i < 4; i++) begin
      obf_key[32*i +: 32] = $urandom;
    end
    for (i = 0; i < 8; i++) begin
      obf_uds_seed[32*i +: 32] = $urandom;
    end
    for (i = 0; i < 4; i++) begin
      obf_field_entropy[32*i +: 32] = $urandom;
    end
    repeat (RESET_CYCLES) @(negedge clk);
    reset_n = 1'b1;

    // Test 1 checks idle outputs and STATUS after reset
    begin_test();
    if (kv_write_en !== 1'b0) report_mismatch("kv_write_en", 64'd0, 64'(kv_write_en));
    if (clear_obf_secrets !== 1'b0) begin
      report_mismatch("clear_obf_secrets", 64'd0, 64'(clear_obf_secrets));
    end
    if (error_intr !== 1'b0) report_mismatch("error_intr", 64'd0, 64'(error_intr));
    if (notif_intr !== 1'b0) report_mismatch("notif_intr", 64'd0, 64'(notif_intr));
    reg_read(REG_STATUS, rd);
    if (rd !== status_word(1'b1, 1'b0, 1'b0, 1'b0, 1'b0)) begin
      report_mismatch("STATUS", 64'(status_word(1'b1, 1'b0, 1'b0, 1'b0, 1'b0)), 64'(rd));
    end
    end_test(1, "reset state");

    // Test 2 runs a UDS flow with notif enabled
    begin_test();
    iv_a[31:0]  = $urandom;
    iv_a[63:32] = $urandom;
    dest_a      = doe_dest_t'($urandom);
    reg_write(REG_IV0, iv_a[31:0]);
    reg_write(REG_IV1, iv_a[63:32]);
    reg_write(REG_INTR_EN, intr_word(1'b0, 1'b1));
    expect_flow(iv_a, obf_uds_seed, UDS_BLOCKS, dest_a);
    kv_before = kv_count;
    reg_write(REG_CTRL, ctrl_word(CMD_UDS, dest_a));
    wait_status_valid();
    if (kv_count - kv_before != UDS_BLOCKS) begin
      report_mismatch("kv write count", 64'(UDS_BLOCKS), 64'(kv_count - kv_before));
    end
    reg_read(REG_STATUS, rd);
    if (rd !== status_word(1'b1, 1'b1, 1'b1, 1'b0, 1'b0)) begin
      report_mismatch("STATUS", 64'(status_word(1'b1, 1'b1, 1'b1, 1'b0, 1'b0)), 64'(rd));
    end
    if (notif_intr !== 1'b1) report_mismatch("notif_intr", 64'd1, 64'(notif_intr));
    end_test(2, "uds flow");

    // Test 3 clears notif and runs FE under a fresh IV
    begin_test();
    reg_write(REG_INTR_STS, intr_word(1'b0, 1'b1));
    if (notif_intr !== 1'b0) report_mismatch("notif_intr", 64'd0, 64'(notif_intr));
    iv_b[31:0]  = $urandom;
    iv_b[63:32] = $urandom;
    dest_b      = doe_dest_t'($urandom);
    reg_write(REG_IV0, iv_b[31:0]);
    reg_write(REG_IV1, iv_b[63:32]);
    expect_flow(iv_b, doe_uds_t'(obf_field_entropy), FE_BLOCKS, dest_b);
    kv_before = kv_count;
    reg_write(REG_CTRL, ctrl_word(CMD_FE, dest_b));
    wait_status_valid();
    if (kv_count - kv_before != FE_BLOCKS) begin
      report_mismatch("kv write count", 64'(FE_BLOCKS), 64'(kv_count - kv_before));
    end
    reg_read(REG_STATUS, rd);
    if (rd !== status_word(1'b1, 1'b1, 1'b1, 1'b1, 1'b0)) begin
      report_mismatch("STATUS", 64'(status_word(1'b1, 1'b1, 1'b1, 1'b1, 1'b0)), 64'(rd));
    end
    end_test(3, "notif clear and fe flow");

    // Test 4 expects a locked UDS to be refused
    begin_test();
    reg_write(REG_INTR_EN, intr_word(1'b1, 1'b1));
    kv_before = kv_count;
    reg_write(REG_CTRL, ctrl_word(CMD_UDS, dest_b));
    repeat (3) @(negedge clk);
    if (error_intr !== 1'b1) report_mismatch("error_intr", 64'd1, 64'(error_intr));
    reg_read(REG_CTRL, rd);
    if (rd !== ctrl_word(CMD_IDLE, dest_b)) begin
      report_mismatch("CTRL", 64'(ctrl_word(CMD_IDLE, dest_b)), 64'(rd));
    end
    // Valid dropped by the CTRL write and no flow_done since
    reg_read(REG_STATUS, rd);
    if (rd !== status_word(1'b1, 1'b0, 1'b1, 1'b1, 1'b0)) begin
      report_mismatch("STATUS", 64'(status_word(1'b1, 1'b0, 1'b1, 1'b1, 1'b0)), 64'(rd));
    end
    // An accepted flow would write its first block by now
    repeat (BLOCK_CYCLES) @(negedge clk);
    if (kv_count != kv_before) report_mismatch("kv write count", 64'd0, 64'(kv_count - kv_before));
    end_test(4, "locked uds rejected");

    // Test 5 clears secrets and then expects FE refused
    begin_test();
    reg_write(REG_INTR_STS, intr_word(1'b1, 1'b0));
    if (error_intr !== 1'b0) report_mismatch("error_intr", 64'd0, 64'(error_intr));
    clr_before = clear_count;
    reg_write(REG_CTRL, ctrl_word(CMD_CLEAR, dest_a));
    repeat (2) @(negedge clk);
    if (clear_count - clr_before != 1) begin
      report_mismatch("clear_obf_secrets pulses", 64'd1, 64'(clear_count - clr_before));
    end
    reg_read(REG_STATUS, rd);
    if (rd !== status_word(1'b1, 1'b1, 1'b1, 1'b1, 1'b1)) begin
      report_mismatch("STATUS", 64'(status_word(1'b1, 1'b1, 1'b1, 1'b1, 1'b1)), 64'(rd));
    end
    reg_read(REG_CTRL, rd);
    if (rd !== ctrl_word(CMD_IDLE, dest_a)) begin
      report_mismatch("CTRL", 64'(ctrl_word(CMD_IDLE, dest_a)), 64'(rd));
    end
    kv_before = kv_count;
    reg_write(REG_CTRL, ctrl_word(CMD_FE, dest_a));
    repeat (3) @(negedge clk);
    if (error_intr !== 1'b1) report_mismatch("error_intr", 64'd1, 64'(error_intr));
    reg_read(REG_CTRL, rd);
    if (rd !== ctrl_word(CMD_IDLE, dest_a)) begin
      report_mismatch("CTRL", 64'(ctrl_word(CMD_IDLE, dest_a)), 64'(rd));
    end
    repeat (BLOCK_CYCLES) @(negedge clk);
    if (kv_count != kv_before) report_mismatch("kv write count", 64'd0, 64'(kv_count - kv_before));
    end_test(5, "clear secrets");

    // Test 6 reads back IV and unmapped offsets
    begin_test();
    reg_write(REG_IV0, 32'ha5a5_0f0f);
    reg_write(REG_IV1, 32'h5a5a_f0f0);
    reg_read(REG_IV0, rd);
    if (rd !== 32'ha5a5_0f0f) report_mismatch("IV0", 64'h0000_0000_a5a5_0f0f, 64'(rd));
    reg_read(REG_IV1, rd);
    if (rd !== 32'h5a5a_f0f0) report_mismatch("IV1", 64'h0000_0000_5a5a_f0f0, 64'(rd));
    reg_read(8'h18, rd);
    if (rd !== 32'd0) report_mismatch("read at 0x18", 64'd0, 64'(rd));
    reg_read(8'hfc, rd);
    if (rd !== 32'd0) report_mismatch("read at 0xfc", 64'd0, 64'(rd));
    end_test(6, "register readback");

    if (exp_data.size() != 0) begin
      $display("%0d expected key vault writes never arrived", exp_data.size());
      errors++;
    end
    $display("summary: %0d tests run, %0d failing, %0d check errors",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+testbench
verilog/doe_pkg.sv
verilog/doe_core_if.sv
verilog/doe_reg_block.sv
verilog/doe_cbc_core.sv
verilog/doe_flow_ctrl.sv
verilog/doe_cbc.sv
testbench/doe_cbc_tb.sv

// File: Makefile
VERILATOR  = verilator
VFLAGS     = --binary --timing -j 0
LINT_FLAGS = --lint-only --timing
TOP        = doe_cbc_tb
FILELIST   = list.f
BUILD_DIR  = obj_dir
PASS_MSG   = all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# Fails unless the pass message shows up as a line of its own
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
